/* hw/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width
`define XLEN 32

// register index width, 32 registers
`define REG_ADDR_W 5

`define RESET_PC 32'h8000_0000

`endif

/* hw/rv_isa_pkg.sv */
`include "rv_defines.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [2:0] funct3_t;

  // major opcodes of the kept RV32I subset
  typedef enum logic [6:0] {
    opc_op     = 7'b011_0011,
    opc_op_imm = 7'b001_0011,
    opc_load   = 7'b000_0011,
    opc_store  = 7'b010_0011,
    opc_branch = 7'b110_0011,
    opc_jal    = 7'b110_1111,
    opc_jalr   = 7'b110_0111,
    opc_lui    = 7'b011_0111,
    opc_auipc  = 7'b001_0111
  } opcode_e;

  // branch compare kinds
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // alu classes, shared by op and op_imm
  localparam funct3_t f3_add  = 3'b000; // add, sub
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101; // srl, sra
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  localparam int unsigned FUNCT7_ALT = 5; // funct7 bit for sub and sra

endpackage

/* hw/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  // operation performed by the execute stage alu
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // where the register writeback value comes from
  typedef enum logic [2:0] {
    wb_alu,
    wb_mem,
    wb_pc_plus4,  // link address for jal and jalr
    wb_imm,       // lui
    wb_pc_target  // auipc
  } wb_src_e;

endpackage

/* hw/rv_ifs.sv */
interface decode_if;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  word_t pc;
  word_t pc_plus4;
  word_t imm;       // already sign extended
  alu_op_e alu_op;
  logic use_imm;    // second alu operand is imm, not rs2
  logic is_branch;
  logic is_jal;
  logic is_jalr;
  funct3_t funct3;
  wb_src_e wb_src;
  reg_addr_t rd;
  logic reg_we;
  logic mem_re;
  logic mem_we;

  modport fd (output pc, pc_plus4, imm, alu_op, use_imm, is_branch, is_jal, is_jalr,
              funct3, wb_src, rd, reg_we, mem_re, mem_we);
  modport ex (input pc, pc_plus4, imm, alu_op, use_imm, is_branch, is_jal, is_jalr,
              funct3, wb_src, rd, reg_we, mem_re, mem_we);
endinterface

interface regread_if;
  import rv_isa_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t rs1_data;
  word_t rs2_data;

  modport fd (output rs1_addr, rs2_addr);
  modport rf (input rs1_addr, rs2_addr, output rs1_data, rs2_data);
  modport ex (input rs1_data, rs2_data);
endinterface

/* hw/rv_fetch_decode.sv */
`include "rv_defines.svh"

module rv_fetch_decode (
  input  logic              clk,
  input  logic              rst,
  input  rv_isa_pkg::word_t inst,
  input  rv_isa_pkg::word_t next_pc,
  output rv_isa_pkg::word_t pc,
  decode_if.fd              dec,
  regread_if.fd             rd_req
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  opcode_e opcode;
  funct3_t funct3;
  logic    funct7_alt;
  word_t   imm_i;
  word_t   imm_shamt;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;

  // alu class from funct3; sub only exists in the register form
  function automatic alu_op_e alu_sel(funct3_t f3, logic alt, logic is_reg);
    case (f3)
      f3_add:  return (alt && is_reg) ? alu_sub : alu_add;
      f3_sll:  return alu_sll;
      f3_slt:  return alu_slt;
      f3_sltu: return alu_sltu;
      f3_xor:  return alu_xor;
      f3_sr:   return alt ? alu_sra : alu_srl;
      f3_or:   return alu_or;
      f3_and:  return alu_and;
      default: return alu_add;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= next_pc; // one instruction per clock
    end
  end

  assign dec.pc       = pc;
  assign dec.pc_plus4 = pc + word_t'(4);

  assign opcode     = opcode_e'(inst[6:0]);
  assign funct3     = inst[14:12];
  assign funct7_alt = inst[25 + FUNCT7_ALT];

  assign rd_req.rs1_addr = inst[19:15];
  assign rd_req.rs2_addr = inst[24:20];
  assign dec.rd          = inst[11:7];
  assign dec.funct3      = funct3;

  assign imm_i     = {{20{inst[31]}}, inst[31:20]};
  assign imm_shamt = word_t'(inst[24:20]); // slli, srli, srai
  assign imm_s     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b     = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u     = {inst[31:12], 12'h000};
  assign imm_j     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec.imm       = imm_i;
    dec.alu_op    = alu_add;
    dec.use_imm   = 1'b0;
    dec.is_branch = 1'b0;
    dec.is_jal    = 1'b0;
    dec.is_jalr   = 1'b0;
    dec.wb_src    = wb_alu;
    dec.reg_we    = 1'b0;
    dec.mem_re    = 1'b0;
    dec.mem_we    = 1'b0;
    case (opcode)
      opc_op: begin
        dec.alu_op = alu_sel(funct3, funct7_alt, 1'b1);
        dec.reg_we = 1'b1;
      end
      opc_op_imm: begin
        dec.alu_op  = alu_sel(funct3, funct7_alt, 1'b0);
        dec.imm     = (funct3 == f3_sll || funct3 == f3_sr) ? imm_shamt : imm_i;
        dec.use_imm = 1'b1;
        dec.reg_we  = 1'b1;
      end
      opc_load: begin
        dec.use_imm = 1'b1; // address is rs1 + imm
        dec.wb_src  = wb_mem;
        dec.reg_we  = 1'b1;
        dec.mem_re  = 1'b1;
      end
      opc_store: begin
        dec.imm     = imm_s;
        dec.use_imm = 1'b1;
        dec.mem_we  = 1'b1;
      end
      opc_branch: begin
        dec.imm       = imm_b; // alu compares rs1 with rs2
        dec.is_branch = 1'b1;
      end
      opc_jal: begin
        dec.imm    = imm_j;
        dec.is_jal = 1'b1;
        dec.wb_src = wb_pc_plus4;
        dec.reg_we = 1'b1;
      end
      opc_jalr: begin
        dec.is_jalr = 1'b1;
        dec.wb_src  = wb_pc_plus4;
        dec.reg_we  = 1'b1;
      end
      opc_lui: begin
        dec.imm    = imm_u;
        dec.wb_src = wb_imm;
        dec.reg_we = 1'b1;
      end
      opc_auipc: begin
        dec.imm    = imm_u;
        dec.wb_src = wb_pc_target;
        dec.reg_we = 1'b1;
      end
      default: ; // anything else retires as a nop
    endcase
    if (rst) begin
      dec.reg_we = 1'b0;
      dec.mem_re = 1'b0;
      dec.mem_we = 1'b0;
    end
  end

endmodule

/* hw/rv_regfile.sv */
`include "rv_defines.svh"

module rv_regfile (
  input logic                   clk,
  regread_if.rf                 rd_port,
  input logic                   wb_we,
  input rv_isa_pkg::reg_addr_t  wb_addr,
  input rv_isa_pkg::word_t      wb_data
);
  import rv_isa_pkg::*;

  localparam int unsigned NUM_REGS = 2 ** `REG_ADDR_W;

  word_t regs [NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wb_we && wb_addr != '0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // combinational reads, x0 forced to zero
  assign rd_port.rs1_data = (rd_port.rs1_addr == '0) ? '0 : regs[rd_port.rs1_addr];
  assign rd_port.rs2_data = (rd_port.rs2_addr == '0) ? '0 : regs[rd_port.rs2_addr];

endmodule

/* hw/rv_execute.sv */
`include "rv_defines.svh"

module rv_execute (
  decode_if.ex                  dec,
  regread_if.ex                 rd_data,
  output rv_isa_pkg::word_t     next_pc,
  output rv_isa_pkg::word_t     dmem_addr,
  output rv_isa_pkg::word_t     dmem_wdata,
  output logic [3:0]            dmem_wmask,
  output logic                  dmem_we,
  output logic                  dmem_re,
  input  rv_isa_pkg::word_t     dmem_rdata,
  output logic                  wb_we,
  output rv_isa_pkg::reg_addr_t wb_addr,
  output rv_isa_pkg::word_t     wb_data
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  localparam int unsigned MSB = `XLEN - 1;

  word_t op_a;
  word_t op_b;
  word_t sum;
  word_t diff;
  word_t alu_res;
  word_t target;
  word_t jump_target;
  logic  carry;
  logic  overflow;
  logic  is_eq;
  logic  is_lt;
  logic  is_ltu;
  logic  branch_cond;
  logic  take_jump;
  logic [$clog2(`XLEN)-1:0] shamt;

  assign op_a  = rd_data.rs1_data;
  assign op_b  = dec.use_imm ? dec.imm : rd_data.rs2_data;
  assign sum   = op_a + op_b;
  assign shamt = op_b[$clog2(`XLEN)-1:0];

  // a - b as a + ~b + 1; carry out low means a borrow
  assign {carry, diff} = {1'b0, op_a} + {1'b0, ~op_b} + {{`XLEN{1'b0}}, 1'b1};
  assign overflow = (op_a[MSB] != op_b[MSB]) && (diff[MSB] != op_a[MSB]);

  assign is_eq  = (diff == '0);
  assign is_lt  = diff[MSB] ^ overflow;
  assign is_ltu = ~carry;

  always_comb begin
    case (dec.alu_op)
      alu_add:  alu_res = sum;
      alu_sub:  alu_res = diff;
      alu_sll:  alu_res = op_a << shamt;
      alu_slt:  alu_res = word_t'(is_lt);
      alu_sltu: alu_res = word_t'(is_ltu);
      alu_xor:  alu_res = op_a ^ op_b;
      alu_srl:  alu_res = op_a >> shamt;
      alu_sra:  alu_res = word_t'($signed(op_a) >>> shamt);
      alu_or:   alu_res = op_a | op_b;
      alu_and:  alu_res = op_a & op_b;
      default:  alu_res = sum;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      f3_beq:  branch_cond = is_eq;
      f3_bne:  branch_cond = !is_eq;
      f3_blt:  branch_cond = is_lt;
      f3_bge:  branch_cond = !is_lt;
      f3_bltu: branch_cond = is_ltu;
      f3_bgeu: branch_cond = !is_ltu;
      default: branch_cond = 1'b0; // 010 and 011 are not branches
    endcase
  end

  // pc relative target, also the auipc result
  assign target      = (dec.is_jalr ? op_a : dec.pc) + dec.imm;
  assign jump_target = dec.is_jalr ? {target[MSB:1], 1'b0} : target;
  assign take_jump   = dec.is_jal || dec.is_jalr || (dec.is_branch && branch_cond);
  assign next_pc     = take_jump ? jump_target : dec.pc_plus4;

  // word accesses only
  assign dmem_addr  = sum;
  assign dmem_wdata = rd_data.rs2_data;
  assign dmem_wmask = 4'b1111;
  assign dmem_we    = dec.mem_we;
  assign dmem_re    = dec.mem_re;

  assign wb_we   = dec.reg_we;
  assign wb_addr = dec.rd;

  always_comb begin
    case (dec.wb_src)
      wb_alu:       wb_data = alu_res;
      wb_mem:       wb_data = dmem_rdata;
      wb_pc_plus4:  wb_data = dec.pc_plus4;
      wb_imm:       wb_data = dec.imm;
      wb_pc_target: wb_data = target;
      default:      wb_data = alu_res;
    endcase
  end

endmodule

/* hw/rv_core.sv */
module rv_core (
  input  logic              clk,
  input  logic              rst,
  output rv_isa_pkg::word_t pc,
  input  rv_isa_pkg::word_t inst,
  output rv_isa_pkg::word_t dmem_addr,
  output rv_isa_pkg::word_t dmem_wdata,
  output logic [3:0]        dmem_wmask,
  output logic              dmem_we,
  output logic              dmem_re,
  input  rv_isa_pkg::word_t dmem_rdata
);
  import rv_isa_pkg::*;

  word_t     next_pc;
  logic      wb_we;
  reg_addr_t wb_addr;
  word_t     wb_data;

  decode_if  dec ();
  regread_if rd ();

  rv_fetch_decode u_fetch_decode (
    .clk     (clk),
    .rst     (rst),
    .inst    (inst),
    .next_pc (next_pc),
    .pc      (pc),
    .dec     (dec.fd),
    .rd_req  (rd.fd)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rd_port (rd.rf),
    .wb_we   (wb_we),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  rv_execute u_execute (
    .dec        (dec.ex),
    .rd_data    (rd.ex),
    .next_pc    (next_pc),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .dmem_rdata (dmem_rdata),
    .wb_we      (wb_we),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data)
  );

endmodule

/* testbench/rv_core_assert.sv */
`include "rv_defines.svh"

module rv_core_assert (
  input logic              clk,
  input logic              rst,
  input rv_isa_pkg::word_t pc,
  input rv_isa_pkg::word_t inst,
  input rv_isa_pkg::word_t dmem_addr,
  input logic [3:0]        dmem_wmask,
  input logic              dmem_we,
  input logic              dmem_re
);
  import rv_isa_pkg::*;

  int    fail_count = 0;
  word_t jal_imm;
  logic  is_flow;

  // 21 bit signed offset, widened by the cast
  assign jal_imm = word_t'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
  assign is_flow = inst[6:0] == opc_branch || inst[6:0] == opc_jal || inst[6:0] == opc_jalr;

  // first cycle out of reset
  reset_state: assert property (@(posedge clk)
    $fell(rst) |-> pc == `RESET_PC && !dmem_we && !dmem_re)
    else begin
      fail_count++;
      $error("pc or data port not in reset state after reset release");
    end

  seq_pc: assert property (@(posedge clk) disable iff (rst)
    !is_flow |=> pc == $past(pc) + 32'd4)
    else begin
      fail_count++;
      $error("pc did not advance by 4");
    end

  jal_pc: assert property (@(posedge clk) disable iff (rst)
    inst[6:0] == opc_jal |=> pc == $past(pc) + $past(jal_imm))
    else begin
      fail_count++;
      $error("jal did not reach its target");
    end

  no_rw_overlap: assert property (@(posedge clk) !(dmem_we && dmem_re))
    else begin
      fail_count++;
      $error("read and write enables high together");
    end

  // word accesses only
  word_access: assert property (@(posedge clk)
    (dmem_we || dmem_re) |-> dmem_addr[1:0] == 2'b00 && dmem_wmask == 4'b1111)
    else begin
      fail_count++;
      $error("data access is misaligned or not a full word");
    end

endmodule

/* testbench/rv_core_tb.sv */
`include "rv_defines.svh"

module rv_core_tb;
  import rv_isa_pkg::*;

  localparam word_t DONE_ADDR = 32'h0000_1000;
  localparam int SUB_IDX = 200;  // subroutine
  localparam int FAIL_IDX = 220; // fail block
  localparam int TIMEOUT = 2000;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  word_t      pc;
  word_t      inst;
  word_t      dmem_addr;
  word_t      dmem_wdata;
  logic [3:0] dmem_wmask;
  logic       dmem_we;
  logic       dmem_re;
  word_t      dmem_rdata;

  word_t imem [256];
  word_t dmem [256];
  int    idx;
  int    errors = 0;

  rv_core DUT (.*);

  bind rv_core rv_core_assert u_assert (.*);

  always #5 clk = ~clk;

  // combinational memory models
  assign inst       = imem[8'((pc - `RESET_PC) >> 2)];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  function automatic word_t encode_r(int f7, int rs2, int rs1, int f3, int rd);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'(opc_op)};
  endfunction

  function automatic word_t encode_i(word_t imm, int rs1, int f3, int rd, logic [6:0] opc);
    return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), opc};
  endfunction

  function automatic word_t encode_s(word_t imm, int rs2, int rs1);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'(opc_store)};
  endfunction

  function automatic word_t encode_b(word_t imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'(opc_branch)};
  endfunction

  function automatic word_t encode_u(word_t imm20, int rd, logic [6:0] opc);
    return {imm20[19:0], 5'(rd), opc};
  endfunction

  function automatic word_t encode_j(word_t imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'(opc_jal)};
  endfunction

  task automatic emit(word_t w);
    imem[idx] = w;
    idx++;
  endtask

  task automatic addi(int rd, int rs1, int imm);
    emit(encode_i(imm, rs1, 0, rd, opc_op_imm));
  endtask

  task automatic branch_to_fail(int f3, int rs1, int rs2);
    emit(encode_b((FAIL_IDX - idx) * 4, rs2, rs1, f3));
  endtask

  task automatic jump_to_fail();
    emit(encode_j((FAIL_IDX - idx) * 4, 0));
  endtask

  // x31 carries the error code of the next check
  task automatic expect_equal(int ra, int rb);
    addi(31, 31, 1);
    branch_to_fail(1, ra, rb);
  endtask

  task automatic alu_check(word_t w, int expected);
    emit(w);
    addi(5, 0, expected);
    expect_equal(4, 5);
  endtask

  task automatic branch_pair(int f3, int ta, int tb, int na, int nb);
    emit(encode_b(8, tb, ta, f3)); // taken skips the jump
    jump_to_fail();
    branch_to_fail(f3, na, nb);
  endtask

  task automatic load_program();
    int a;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0000_0013; // nop
      dmem[i] = '0;
    end
    idx = 0;
    addi(31, 0, 16);
    emit(encode_u('h00001, 30, opc_lui));
    emit(encode_u('h12345, 1, opc_lui));
    addi(1, 1, 'h678);
    addi(2, 0, -5);
    addi(3, 0, 3);
    alu_check(encode_r(0, 3, 2, 0, 4), -2);
    alu_check(encode_r('h20, 2, 3, 0, 4), 8);
    alu_check(encode_r(0, 3, 3, 1, 4), 24);
    alu_check(encode_r(0, 3, 2, 2, 4), 1);
    alu_check(encode_r(0, 3, 2, 3, 4), 0);
    alu_check(encode_r(0, 3, 2, 4, 4), -8);
    alu_check(encode_r('h20, 3, 2, 5, 4), -1);
    alu_check(encode_r(0, 3, 2, 6, 4), -5);
    alu_check(encode_r(0, 3, 1, 7, 4), 0);
    emit(encode_r(0, 3, 2, 5, 4)); // srl gives 0x1fffffff
    emit(encode_u('h20000, 5, opc_lui));
    addi(5, 5, -1);
    expect_equal(4, 5);
    alu_check(encode_i(100, 2, 0, 4, opc_op_imm), 95);
    alu_check(encode_i('h0ff, 1, 7, 4, opc_op_imm), 120);
    alu_check(encode_i('h070, 3, 6, 4, opc_op_imm), 115);
    alu_check(encode_i(-1, 2, 4, 4, opc_op_imm), 4);
    alu_check(encode_i(-4, 2, 2, 4, opc_op_imm), 1);
    alu_check(encode_i(-1, 3, 3, 4, opc_op_imm), 1);
    alu_check(encode_i(4, 3, 1, 4, opc_op_imm), 48);
    alu_check(encode_i(28, 2, 5, 4, opc_op_imm), 15);
    alu_check(encode_i('h401, 2, 5, 4, opc_op_imm), -3); // srai
    branch_pair(0, 2, 2, 2, 3);
    branch_pair(1, 2, 3, 3, 3);
    branch_pair(4, 2, 3, 3, 2);
    branch_pair(5, 3, 2, 2, 3);
    branch_pair(6, 3, 2, 2, 3);
    branch_pair(7, 2, 3, 3, 2);
    emit(encode_j((SUB_IDX - idx) * 4, 10));
    addi(5, 0, 77);
    expect_equal(11, 5);
    a = idx;
    emit(encode_u(1, 6, opc_auipc));
    emit(encode_u('h80001, 7, opc_lui));
    addi(7, 7, 4 * a);
    expect_equal(6, 7);
    addi(8, 0, 'h100);
    emit(encode_s(0, 1, 8));
    emit(encode_s(4, 2, 8));
    emit(encode_i(0, 8, 2, 9, opc_load));
    expect_equal(9, 1);
    emit(encode_i(4, 8, 2, 9, opc_load));
    expect_equal(9, 2);
    addi(12, 0, 1);
    emit(encode_s(0, 12, 30)); // report success
    emit(encode_j(0, 0));
    idx = SUB_IDX;
    addi(11, 0, 77);
    emit(encode_i(1, 10, 0, 0, opc_jalr)); // bit 0 must be dropped
    idx = FAIL_IDX;
    emit(encode_s(0, 31, 30));
    emit(encode_j(0, 0));
  endtask

  initial begin
    int    cycles;
    logic  done;
    word_t done_val;
    load_program();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < TIMEOUT) begin
      @(posedge clk);
      if (!rst && dmem_we && dmem_addr == DONE_ADDR) begin
        done = 1'b1;
        done_val = dmem_wdata;
      end
      cycles++;
    end
    if (!done) begin
      $display("program never finished within %0d cycles", TIMEOUT);
      errors++;
    end else if (done_val != 32'd1) begin
      $display("ERR %0t: done value %0d, expected 1", $time, done_val);
      errors++;
    end
    repeat (4) @(negedge clk);
    $display("testbench errors %0d, assertion failures %0d", errors, DUT.u_assert.fail_count);
    if (errors == 0 && DUT.u_assert.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/rv_ifs.sv
hw/rv_fetch_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_core.sv
testbench/rv_core_assert.sv
testbench/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
RTL_TOP   ?= rv_core
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
